/* hw/mmioPkg.sv */
package mmioPkg;

	// bus widths
	localparam int AddrWidth = 32;
	localparam int DataWidth = 32;
	localparam int OpmWidth = 5;
	localparam int OkWidth = 2;

	// operation modes, held by the requester until the status reads OK
	localparam logic [OpmWidth-1:0] OpmNone = 5'h00;
	localparam logic [OpmWidth-1:0] OpmLoad = 5'h0A;
	localparam logic [OpmWidth-1:0] OpmStore = 5'h12;

	// status codes
	localparam logic [OkWidth-1:0] OkReady = 2'b00;
	localparam logic [OkWidth-1:0] OkOk = 2'b01;

	// hex nibble to active-low segments, bit 7 is the dp and stays dark
	function automatic logic [7:0] segPattern(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~{1'b0, lit};
	endfunction

endpackage

/* hw/mmioTarget.sv */
`timescale 1ns/1ps

interface mmioTarget;
	import mmioPkg::*;

	// request side, copied from the requester
	logic [AddrWidth-1:0] addr;
	logic [OpmWidth-1:0] opm;
	logic [DataWidth-1:0] wdata;

	// response side, registered in the peripheral
	logic [DataWidth-1:0] rdata;
	logic [OkWidth-1:0] ok;

	modport bus (
		output addr,
		output opm,
		output wdata,
		input rdata,
		input ok
	);

	modport dev (
		input addr,
		input opm,
		input wdata,
		output rdata,
		output ok
	);

endinterface

/* hw/tickGen.sv */
`timescale 1ns/1ps

module tickGen #(
	parameter int CyclesPerUs = 25,
	parameter int ScanPeriodUs = 1000
) (
	input logic clock,
	input logic arstN_i,
	output logic tickUs_o,
	output logic tickScan_o
);

	localparam int PreWidth = $clog2(CyclesPerUs + 1);
	localparam int UsWidth = $clog2(ScanPeriodUs + 1);

	logic [PreWidth-1:0] preCnt;
	logic [UsWidth-1:0] usCnt;

	always_ff @(posedge clock or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			preCnt <= PreWidth'(CyclesPerUs - 1);
			usCnt <= UsWidth'(ScanPeriodUs - 1);
			tickUs_o <= 1'b0;
			tickScan_o <= 1'b0;
		end
		else if (preCnt == '0)
		begin
			preCnt <= PreWidth'(CyclesPerUs - 1);
			tickUs_o <= 1'b1;
			// one scan tick per digit period
			if (usCnt == '0)
			begin
				usCnt <= UsWidth'(ScanPeriodUs - 1);
				tickScan_o <= 1'b1;
			end
			else
			begin
				usCnt <= usCnt - 1'b1;
				tickScan_o <= 1'b0;
			end
		end
		else
		begin
			preCnt <= preCnt - 1'b1;
			tickUs_o <= 1'b0;
			tickScan_o <= 1'b0;
		end
	end

endmodule

/* hw/mmioResponder.sv */
`timescale 1ns/1ps

module mmioResponder #(
	parameter int MissLimit = 15
) (
	input logic clock,
	input logic arstN_i,
	input logic [mmioPkg::AddrWidth-1:0] reqAddr_i,
	input logic [mmioPkg::OpmWidth-1:0] reqOpm_i,
	input logic [mmioPkg::DataWidth-1:0] reqData_i,
	output logic [mmioPkg::DataWidth-1:0] respData_o,
	output logic [mmioPkg::OkWidth-1:0] respOk_o,
	output logic busMiss_o,
	mmioTarget.bus gpioBus,
	mmioTarget.bus segBus
);
	import mmioPkg::*;

	localparam int CntWidth = $clog2(MissLimit + 2);

	logic [CntWidth-1:0] missCnt;
	logic missOk;
	logic unclaimed;

	// every target sees the same request, decoding is theirs
	assign gpioBus.addr = reqAddr_i;
	assign gpioBus.opm = reqOpm_i;
	assign gpioBus.wdata = reqData_i;
	assign segBus.addr = reqAddr_i;
	assign segBus.opm = reqOpm_i;
	assign segBus.wdata = reqData_i;

	assign unclaimed = (gpioBus.ok == OkReady) && (segBus.ok == OkReady);

	// first target not READY wins, gpio first
	always_comb
	begin
		respData_o = '0;
		respOk_o = OkReady;
		if (gpioBus.ok != OkReady)
		begin
			respData_o = gpioBus.rdata;
			respOk_o = gpioBus.ok;
		end
		else if (segBus.ok != OkReady)
		begin
			respData_o = segBus.rdata;
			respOk_o = segBus.ok;
		end
		else if (missOk)
			respOk_o = OkOk;
	end

	// timeout for requests nobody answers
	always_ff @(posedge clock or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			missCnt <= '0;
			missOk <= 1'b0;
			busMiss_o <= 1'b0;
		end
		else if (reqOpm_i == OpmNone)
		begin
			missCnt <= '0;
			missOk <= 1'b0;
		end
		else if (unclaimed)
		begin
			if (missCnt == CntWidth'(MissLimit))
			begin
				missOk <= 1'b1;
				// sticky until reset
				busMiss_o <= 1'b1;
			end
			else
				missCnt <= missCnt + 1'b1;
		end
	end

endmodule

/* hw/gpioRegs.sv */
`timescale 1ns/1ps

module gpioRegs #(
	parameter logic [mmioPkg::AddrWidth-1:0] GpioBase = 32'hF000E000
) (
	input logic clock,
	input logic arstN_i,
	input logic tickUs_i,
	input logic [mmioPkg::DataWidth-1:0] pinsIn_i,
	output logic [mmioPkg::DataWidth-1:0] pinsOut_o,
	output logic [mmioPkg::DataWidth-1:0] pinsDir_o,
	mmioTarget.dev bus
);
	import mmioPkg::*;

	logic [DataWidth-1:0] pinsMeta;
	logic [DataWidth-1:0] pinsSync;
	logic [DataWidth-1:0] usCount;
	logic [DataWidth-1:0] readVal;
	logic hit;
	logic start;

	// 16-byte window, four word registers
	assign hit = (bus.addr[AddrWidth-1:4] == GpioBase[AddrWidth-1:4]);
	assign start = hit && (bus.opm != OpmNone) && (bus.ok == OkReady);

	always_comb
	begin
		case (bus.addr[3:0])
			4'h0: readVal = pinsOut_o;
			4'h4: readVal = pinsSync;
			4'h8: readVal = pinsDir_o;
			4'hC: readVal = usCount;
			default: readVal = '0;
		endcase
	end

	// two-flop input synchronizer
	always_ff @(posedge clock)
	begin
		pinsMeta <= pinsIn_i;
		pinsSync <= pinsMeta;
	end

	always_ff @(posedge clock or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			pinsOut_o <= '0;
			pinsDir_o <= '0;
			usCount <= '0;
			bus.ok <= OkReady;
		end
		else
		begin
			if (tickUs_i)
				usCount <= usCount + 1'b1;
			// read-only words swallow stores
			if (start && (bus.opm == OpmStore))
			begin
				case (bus.addr[3:0])
					4'h0: pinsOut_o <= bus.wdata;
					4'h8: pinsDir_o <= bus.wdata;
					default: ;
				endcase
			end
			bus.ok <= (hit && (bus.opm != OpmNone)) ? OkOk : OkReady;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start && (bus.opm == OpmLoad))
			bus.rdata <= readVal;
	end

endmodule

/* hw/sevenSegScan.sv */
`timescale 1ns/1ps

module sevenSegScan #(
	parameter logic [mmioPkg::AddrWidth-1:0] SegBase = 32'hF000E010
) (
	input logic clock,
	input logic arstN_i,
	input logic tickScan_i,
	output logic [7:0] segChar_o,
	output logic [7:0] segSeg_o,
	mmioTarget.dev bus
);
	import mmioPkg::*;

	logic [DataWidth-1:0] dispVal;
	logic [DataWidth-1:0] dispNext;
	logic [2:0] digit;
	logic [2:0] nextDigit;
	logic hit;
	logic start;
	logic storeVal;
	logic lit;

	assign hit = (bus.addr[AddrWidth-1:4] == SegBase[AddrWidth-1:4]);
	assign start = hit && (bus.opm != OpmNone) && (bus.ok == OkReady);
	assign storeVal = start && (bus.opm == OpmStore) && (bus.addr[3:0] == 4'h0);

	// segments follow a store in the same edge as the register
	assign dispNext = storeVal ? bus.wdata : dispVal;
	assign nextDigit = digit + 3'd1;
	// dark until the first scan tick
	assign lit = ~&segChar_o;

	always_ff @(posedge clock or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			dispVal <= '0;
			bus.ok <= OkReady;
		end
		else
		begin
			if (storeVal)
				dispVal <= bus.wdata;
			bus.ok <= (hit && (bus.opm != OpmNone)) ? OkOk : OkReady;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start && (bus.opm == OpmLoad))
			bus.rdata <= (bus.addr[3:0] == 4'h0) ? dispVal : '0;
	end

	// digit scan, starts from 7 so the first tick lands on digit 0
	always_ff @(posedge clock or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			digit <= 3'd7;
			segChar_o <= '1;
			segSeg_o <= '1;
		end
		else if (tickScan_i)
		begin
			digit <= nextDigit;
			segChar_o <= ~(8'd1 << nextDigit);
			segSeg_o <= segPattern(dispNext[{nextDigit, 2'b00} +: 4]);
		end
		else if (lit)
			segSeg_o <= segPattern(dispNext[{digit, 2'b00} +: 4]);
	end

endmodule

/* hw/coreUnit.sv */
`timescale 1ns/1ps

module coreUnit #(
	parameter logic [mmioPkg::AddrWidth-1:0] GpioBase = 32'hF000E000,
	parameter logic [mmioPkg::AddrWidth-1:0] SegBase = 32'hF000E010,
	parameter int CyclesPerUs = 25,
	parameter int ScanPeriodUs = 1000,
	parameter int MissLimit = 15
) (
	input logic clock,
	input logic arstN_i,
	input logic [mmioPkg::AddrWidth-1:0] reqAddr_i,
	input logic [mmioPkg::OpmWidth-1:0] reqOpm_i,
	input logic [mmioPkg::DataWidth-1:0] reqData_i,
	output logic [mmioPkg::DataWidth-1:0] respData_o,
	output logic [mmioPkg::OkWidth-1:0] respOk_o,
	output logic busMiss_o,
	input logic [mmioPkg::DataWidth-1:0] gpioIn_i,
	output logic [mmioPkg::DataWidth-1:0] gpioOut_o,
	output logic [mmioPkg::DataWidth-1:0] gpioDir_o,
	output logic [7:0] segChar_o,
	output logic [7:0] segSeg_o
);

	logic tickUs;
	logic tickScan;

	mmioTarget gpioBus ();
	mmioTarget segBus ();

	tickGen #(
		.CyclesPerUs(CyclesPerUs),
		.ScanPeriodUs(ScanPeriodUs)
	) ticks (
		.clock(clock),
		.arstN_i(arstN_i),
		.tickUs_o(tickUs),
		.tickScan_o(tickScan)
	);

	mmioResponder #(
		.MissLimit(MissLimit)
	) responder (
		.clock(clock),
		.arstN_i(arstN_i),
		.reqAddr_i(reqAddr_i),
		.reqOpm_i(reqOpm_i),
		.reqData_i(reqData_i),
		.respData_o(respData_o),
		.respOk_o(respOk_o),
		.busMiss_o(busMiss_o),
		.gpioBus(gpioBus.bus),
		.segBus(segBus.bus)
	);

	gpioRegs #(
		.GpioBase(GpioBase)
	) gpio (
		.clock(clock),
		.arstN_i(arstN_i),
		.tickUs_i(tickUs),
		.pinsIn_i(gpioIn_i),
		.pinsOut_o(gpioOut_o),
		.pinsDir_o(gpioDir_o),
		.bus(gpioBus.dev)
	);

	sevenSegScan #(
		.SegBase(SegBase)
	) sevSeg (
		.clock(clock),
		.arstN_i(arstN_i),
		.tickScan_i(tickScan),
		.segChar_o(segChar_o),
		.segSeg_o(segSeg_o),
		.bus(segBus.dev)
	);

endmodule

/* sim/coreUnitTb.sv */
`timescale 1ns/1ps

module coreUnitTb;
	import mmioPkg::*;

	localparam logic [31:0] GpioBase = 32'hF000E000;
	localparam logic [31:0] SegBase = 32'hF000E010;
	localparam int CyclesPerUs = 25;
	localparam int ScanPeriodUs = 2;
	localparam int MissLimit = 15;
	localparam int ScanCycles = ScanPeriodUs * CyclesPerUs;
	// all tests together take well under 2000 cycles
	localparam int TimeoutCycles = 20000;

	logic clock;
	logic arstN;
	logic [31:0] reqAddr;
	logic [4:0] reqOpm;
	logic [31:0] reqData;
	logic [31:0] respData;
	logic [1:0] respOk;
	logic busMiss;
	logic [31:0] gpioIn;
	logic [31:0] gpioOut;
	logic [31:0] gpioDir;
	logic [7:0] segChar;
	logic [7:0] segSeg;

	// register model
	logic [31:0] modelOut;
	logic [31:0] modelDir;
	logic [31:0] modelPins;
	logic [31:0] modelDisp;
	logic [31:0] lfsrState;
	logic scanCheck;
	logic [7:0] seenDigits;
	int cycleCount;

	coreUnit #(
		.GpioBase(GpioBase),
		.SegBase(SegBase),
		.CyclesPerUs(CyclesPerUs),
		.ScanPeriodUs(ScanPeriodUs),
		.MissLimit(MissLimit)
	) UUT (
		.clock(clock),
		.arstN_i(arstN),
		.reqAddr_i(reqAddr),
		.reqOpm_i(reqOpm),
		.reqData_i(reqData),
		.respData_o(respData),
		.respOk_o(respOk),
		.busMiss_o(busMiss),
		.gpioIn_i(gpioIn),
		.gpioOut_o(gpioOut),
		.gpioDir_o(gpioDir),
		.segChar_o(segChar),
		.segSeg_o(segSeg)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomWord(output logic [31:0] word);
		for (int i = 0; i < 32; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			word = {word[30:0], lfsrState[0]};
		end
	endtask

	// common-anode hex codes, dp dark
	function automatic logic [7:0] segRef(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hC6;
			4'hD: return 8'hA1;
			4'hE: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	function automatic logic [31:0] expectedLoad(input logic [31:0] addr);
		case (addr)
			GpioBase: return modelOut;
			GpioBase + 32'd4: return modelPins;
			GpioBase + 32'd8: return modelDir;
			SegBase: return modelDisp;
			default: return '0;
		endcase
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// one full handshake, entered 2 ns after an edge
	task automatic mmioAccess(input logic [31:0] addr, input logic [4:0] opm,
			input logic [31:0] wdata, output logic [31:0] rdata, output int cycles);
		reqAddr = addr;
		reqOpm = opm;
		reqData = wdata;
		@(posedge clock);
		#1;
		cycles = 1;
		while (respOk !== OkOk)
		begin
			@(posedge clock);
			#1;
			cycles++;
		end
		rdata = respData;
		#1;
		reqOpm = OpmNone;
		@(posedge clock);
		#2;
	endtask

	task automatic storeWord(input logic [31:0] addr, input logic [31:0] value);
		logic [31:0] unused;
		int cycles;
		mmioAccess(addr, OpmStore, value, unused, cycles);
		checkEq("respOk_o latency", cycles, 1);
		if (addr == GpioBase)
			modelOut = value;
		else if (addr == GpioBase + 32'd8)
			modelDir = value;
		else if (addr == SegBase)
			modelDisp = value;
	endtask

	task automatic loadWord(input logic [31:0] addr, input int latency, output logic [31:0] data);
		int cycles;
		mmioAccess(addr, OpmLoad, '0, data, cycles);
		checkEq("respOk_o latency", cycles, latency);
	endtask

	task automatic loadCheck(input logic [31:0] addr);
		logic [31:0] data;
		loadWord(addr, 1, data);
		checkEq("respData_o", data, expectedLoad(addr));
	endtask

	// new pins, then long enough for the synchronizer
	task automatic drivePins;
		logic [31:0] value;
		randomWord(value);
		gpioIn = value;
		modelPins = value;
		repeat (3) @(posedge clock);
		#2;
	endtask

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	// display scan checker
	always @(negedge clock)
	begin
		if (scanCheck && ($countones(~segChar) == 1))
		begin
			for (int k = 0; k < 8; k++)
			begin
				if (!segChar[k])
				begin
					checkEq("segSeg_o", segSeg, segRef(modelDisp[4*k +: 4]));
					seenDigits[k] = 1'b1;
				end
			end
		end
	end

	initial
	begin
		logic [31:0] value;
		logic [31:0] data;
		logic [31:0] t0;
		logic [31:0] t1;
		int c0;
		int gap;
		arstN = 1'b0;
		reqAddr = '0;
		reqOpm = OpmNone;
		reqData = '0;
		gpioIn = '0;
		modelOut = '0;
		modelDir = '0;
		modelPins = '0;
		modelDisp = '0;
		lfsrState = 32'hd462_36d3;
		scanCheck = 1'b0;
		seenDigits = '0;
		cycleCount = 0;
		repeat (4) @(posedge clock);
		#2;
		arstN = 1'b1;

		// reset state
		checkEq("respOk_o", respOk, OkReady);
		checkEq("busMiss_o", busMiss, 1'b0);
		checkEq("gpioOut_o", gpioOut, '0);
		checkEq("gpioDir_o", gpioDir, '0);
		checkEq("segChar_o", segChar, 8'hFF);
		checkEq("segSeg_o", segSeg, 8'hFF);

		// GPIO output and direction
		for (int n = 0; n < 4; n++)
		begin
			randomWord(value);
			storeWord(GpioBase, value);
			checkEq("gpioOut_o", gpioOut, modelOut);
			randomWord(value);
			storeWord(GpioBase + 32'd8, value);
			checkEq("gpioDir_o", gpioDir, modelDir);
			loadCheck(GpioBase);
			loadCheck(GpioBase + 32'd8);
		end
		drivePins();
		randomWord(value);
		storeWord(GpioBase + 32'd4, value);
		loadCheck(GpioBase + 32'd4);

		// inputs and microsecond timer
		for (int n = 0; n < 4; n++)
		begin
			drivePins();
			loadCheck(GpioBase + 32'd4);
		end
		loadWord(GpioBase + 32'd12, 1, t0);
		c0 = cycleCount;
		randomWord(value);
		repeat (100 + value[7:0]) @(posedge clock);
		#2;
		loadWord(GpioBase + 32'd12, 1, t1);
		gap = cycleCount - c0;
		assert ((t1 >= t0) && ((t1 - t0) <= gap / CyclesPerUs + 1))
		else
		begin
			$display("Timer moved from %0d to %0d over %0d cycles, out of range", t0, t1, gap);
			$display("SIMULATION FAILED");
			$fatal(1);
		end

		// unmapped access times out, then normal traffic resumes
		loadWord(32'h1000_0040, MissLimit + 1, data);
		checkEq("respData_o", data, '0);
		checkEq("busMiss_o", busMiss, 1'b1);
		randomWord(value);
		storeWord(GpioBase, value);
		loadCheck(GpioBase);
		checkEq("busMiss_o", busMiss, 1'b1);

		// display scan over 16 digit periods
		randomWord(value);
		storeWord(SegBase, value);
		seenDigits = '0;
		scanCheck = 1'b1;
		repeat (16 * ScanCycles) @(posedge clock);
		#2;
		scanCheck = 1'b0;
		assert (seenDigits == 8'hFF)
		else
		begin
			$display("Not all eight display digits were scanned, seen mask %b", seenDigits);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
		loadCheck(SegBase);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* sim.f */
hw/mmioPkg.sv
hw/mmioTarget.sv
hw/tickGen.sv
hw/mmioResponder.sv
hw/gpioRegs.sv
hw/sevenSegScan.sv
hw/coreUnit.sv
sim/coreUnitTb.sv

/* Bender.yml */
package:
  name: core_unit

sources:
  - hw/mmioPkg.sv
  - hw/mmioTarget.sv
  - hw/tickGen.sv
  - hw/mmioResponder.sv
  - hw/gpioRegs.sv
  - hw/sevenSegScan.sv
  - hw/coreUnit.sv
  - target: simulation
    files:
      - sim/coreUnitTb.sv
